/* hdl/rename_pkg.sv */
package rename_pkg;

  // ====================
  // sizes
  // ====================

  localparam int slot_num     = 2;
  localparam int arch_reg_num = 32;
  localparam int phy_reg_num  = 64;
  // registers not held by the initial identity mapping
  localparam int fl_depth     = phy_reg_num - arch_reg_num;

  typedef logic [$clog2(arch_reg_num)-1:0] areg_t;
  typedef logic [$clog2(phy_reg_num)-1:0]  preg_t;
  typedef logic [5:0]                      ecode_t;
  typedef logic [1:0]                      plv_t;

  // free list pointer and occupancy
  typedef logic [$clog2(fl_depth)-1:0]     fl_ptr_t;
  typedef logic [$clog2(fl_depth+1)-1:0]   fl_cnt_t;
  // number of slots, 0 to slot_num
  typedef logic [$clog2(slot_num+1)-1:0]   slot_cnt_t;

  // ====================
  // exception codes
  // ====================

  localparam ecode_t ecode_int = 6'h00;
  localparam ecode_t ecode_sys = 6'h0B;
  localparam ecode_t ecode_brk = 6'h0C;
  localparam ecode_t ecode_ine = 6'h0D;
  localparam ecode_t ecode_ipe = 6'h0E;

  localparam plv_t plv_user = 2'd3;

  typedef enum logic [2:0] {
    alu     = 3'd0,
    mdu     = 3'd1,
    mem     = 3'd2,
    branch  = 3'd3,
    priv    = 3'd4,
    syscall = 3'd5,
    brk     = 3'd6
  } instr_class_e;

  // ====================
  // bundle structs
  // ====================

  typedef struct packed {
    logic   valid;
    ecode_t ecode;
  } excp_t;

  typedef struct packed {
    logic         valid;
    instr_class_e instr_class;
    logic         invalid_inst;
    excp_t        fetch_excp;
    areg_t        arch_src0;
    areg_t        arch_src1;
    areg_t        arch_dest;
  } decode_slot_t;

  typedef struct packed {
    decode_slot_t [slot_num-1:0] slot;
  } decode_bundle_t;

  // reorder buffer side, one entry per incoming slot
  typedef struct packed {
    logic  valid;
    areg_t arch_dest;
    logic  dest_valid;
    preg_t ppdest;
    excp_t excp;
  } rob_slot_t;

  // dispatch side, slots without exceptions only
  typedef struct packed {
    logic         valid;
    instr_class_e instr_class;
    logic         src0_valid;
    logic         src1_valid;
    logic         dest_valid;
    preg_t        psrc0;
    preg_t        psrc1;
    preg_t        pdest;
  } disp_slot_t;

  typedef struct packed {
    rob_slot_t  [slot_num-1:0] rob;
    disp_slot_t [slot_num-1:0] disp;
  } rename_out_t;

  // registers released at commit
  typedef struct packed {
    logic  [slot_num-1:0] valid;
    preg_t [slot_num-1:0] preg;
  } free_req_t;

endpackage

/* hdl/free_list.sv */
`timescale 1ns/1ps

module free_list (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  rename_pkg::slot_cnt_t                        alloc_num_i,
  output rename_pkg::preg_t [rename_pkg::slot_num-1:0] head_preg_o,
  output logic                                         ready_o,
  input  rename_pkg::free_req_t                        free_i
);

  rename_pkg::preg_t   mem_q [rename_pkg::fl_depth];
  rename_pkg::fl_ptr_t head_q;
  rename_pkg::fl_ptr_t tail_q;
  rename_pkg::fl_cnt_t cnt_q;

  rename_pkg::fl_ptr_t [rename_pkg::slot_num-1:0] wr_ptr;
  rename_pkg::fl_ptr_t                            tail_d;
  rename_pkg::slot_cnt_t                          push_num;

  // ====================
  // read side
  // ====================

  always_comb begin
    for (int i = 0; i < rename_pkg::slot_num; i++) begin
      head_preg_o[i] = mem_q[head_q + rename_pkg::fl_ptr_t'(i)];
    end
  end

  assign ready_o = cnt_q >= rename_pkg::fl_cnt_t'(rename_pkg::slot_num);

  // ====================
  // write side
  // ====================

  // frees pack at the tail, slot 0 first
  always_comb begin
    tail_d   = tail_q;
    push_num = '0;
    for (int i = 0; i < rename_pkg::slot_num; i++) begin
      wr_ptr[i] = tail_d;
      if (free_i.valid[i]) begin
        tail_d   = tail_d + 1'b1;
        push_num = push_num + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // starts full with the registers above the architectural set
      for (int i = 0; i < rename_pkg::fl_depth; i++) begin
        mem_q[i] <= rename_pkg::preg_t'(rename_pkg::arch_reg_num + i);
      end
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= rename_pkg::fl_cnt_t'(rename_pkg::fl_depth);
    end else begin
      for (int i = 0; i < rename_pkg::slot_num; i++) begin
        if (free_i.valid[i]) begin
          mem_q[wr_ptr[i]] <= free_i.preg[i];
        end
      end
      head_q <= head_q + rename_pkg::fl_ptr_t'(alloc_num_i);
      tail_q <= tail_d;
      cnt_q  <= cnt_q - rename_pkg::fl_cnt_t'(alloc_num_i)
              + rename_pkg::fl_cnt_t'(push_num);
    end
  end

endmodule

/* hdl/alias_table.sv */
`timescale 1ns/1ps

module alias_table (
  input  logic                                         clk,
  input  logic                                         rst_n,
  // lookup
  input  rename_pkg::areg_t [rename_pkg::slot_num-1:0] rd_src0_i,
  input  rename_pkg::areg_t [rename_pkg::slot_num-1:0] rd_src1_i,
  input  rename_pkg::areg_t [rename_pkg::slot_num-1:0] rd_dest_i,
  output rename_pkg::preg_t [rename_pkg::slot_num-1:0] rd_src0_o,
  output rename_pkg::preg_t [rename_pkg::slot_num-1:0] rd_src1_o,
  output rename_pkg::preg_t [rename_pkg::slot_num-1:0] rd_dest_o,
  // update
  input  logic              [rename_pkg::slot_num-1:0] wr_valid_i,
  input  rename_pkg::areg_t [rename_pkg::slot_num-1:0] wr_areg_i,
  input  rename_pkg::preg_t [rename_pkg::slot_num-1:0] wr_preg_i
);

  rename_pkg::preg_t rat_q [rename_pkg::arch_reg_num];

  // ====================
  // lookup
  // ====================

  // table contents only, same-bundle forwarding is done by the caller
  always_comb begin
    for (int i = 0; i < rename_pkg::slot_num; i++) begin
      rd_src0_o[i] = rat_q[rd_src0_i[i]];
      rd_src1_o[i] = rat_q[rd_src1_i[i]];
      rd_dest_o[i] = rat_q[rd_dest_i[i]];
    end
  end

  // ====================
  // update
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // identity map
      for (int a = 0; a < rename_pkg::arch_reg_num; a++) begin
        rat_q[a] <= rename_pkg::preg_t'(a);
      end
    end else begin
      // later slot overrides an earlier one on the same register
      for (int i = 0; i < rename_pkg::slot_num; i++) begin
        if (wr_valid_i[i]) begin
          rat_q[wr_areg_i[i]] <= wr_preg_i[i];
        end
      end
    end
  end

endmodule

/* hdl/reg_renamer.sv */
`timescale 1ns/1ps

module reg_renamer (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  rename_pkg::decode_bundle_t                   in_i,
  input  logic              [rename_pkg::slot_num-1:0] alloc_mask_i,
  input  rename_pkg::slot_cnt_t                        alloc_num_i,
  input  rename_pkg::free_req_t                        free_i,
  output logic                                         fl_ready_o,
  output rename_pkg::preg_t [rename_pkg::slot_num-1:0] pdest_o,
  output rename_pkg::preg_t [rename_pkg::slot_num-1:0] psrc0_o,
  output rename_pkg::preg_t [rename_pkg::slot_num-1:0] psrc1_o,
  output rename_pkg::preg_t [rename_pkg::slot_num-1:0] ppdest_o
);

  rename_pkg::preg_t [rename_pkg::slot_num-1:0] head_preg;
  rename_pkg::areg_t [rename_pkg::slot_num-1:0] src0_areg;
  rename_pkg::areg_t [rename_pkg::slot_num-1:0] src1_areg;
  rename_pkg::areg_t [rename_pkg::slot_num-1:0] dest_areg;
  rename_pkg::preg_t [rename_pkg::slot_num-1:0] rat_src0;
  rename_pkg::preg_t [rename_pkg::slot_num-1:0] rat_src1;
  rename_pkg::preg_t [rename_pkg::slot_num-1:0] rat_dest;

  always_comb begin
    for (int i = 0; i < rename_pkg::slot_num; i++) begin
      src0_areg[i] = in_i.slot[i].arch_src0;
      src1_areg[i] = in_i.slot[i].arch_src1;
      dest_areg[i] = in_i.slot[i].arch_dest;
    end
  end

  // slot 1 skips the head that slot 0 consumes
  assign pdest_o[0] = head_preg[0];
  assign pdest_o[1] = alloc_mask_i[0] ? head_preg[1] : head_preg[0];

  // bypass of slot 0's new mapping into slot 1
  always_comb begin
    psrc0_o  = rat_src0;
    psrc1_o  = rat_src1;
    ppdest_o = rat_dest;
    if (alloc_mask_i[0]) begin
      if (src0_areg[1] == dest_areg[0]) begin
        psrc0_o[1] = pdest_o[0];
      end
      if (src1_areg[1] == dest_areg[0]) begin
        psrc1_o[1] = pdest_o[0];
      end
      if (dest_areg[1] == dest_areg[0]) begin
        ppdest_o[1] = pdest_o[0];
      end
    end
  end

  free_list free_list_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .alloc_num_i (alloc_num_i),
    .head_preg_o (head_preg),
    .ready_o     (fl_ready_o),
    .free_i      (free_i)
  );

  alias_table alias_table_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_src0_i  (src0_areg),
    .rd_src1_i  (src1_areg),
    .rd_dest_i  (dest_areg),
    .rd_src0_o  (rat_src0),
    .rd_src1_o  (rat_src1),
    .rd_dest_o  (rat_dest),
    .wr_valid_i (alloc_mask_i),
    .wr_areg_i  (dest_areg),
    .wr_preg_i  (pdest_o)
  );

endmodule

/* hdl/excp_classifier.sv */
`timescale 1ns/1ps

module excp_classifier (
  input  rename_pkg::decode_bundle_t                   in_i,
  input  logic                                         csr_has_int_i,
  input  rename_pkg::plv_t                             csr_plv_i,
  output rename_pkg::excp_t [rename_pkg::slot_num-1:0] excp_o
);

  function automatic rename_pkg::excp_t raise(input rename_pkg::ecode_t code);
    rename_pkg::excp_t e;
    e.valid = 1'b1;
    e.ecode = code;
    return e;
  endfunction

  // ====================
  // priority per slot
  // ====================

  // int > fetch > ine > ipe > sys > brk
  always_comb begin
    for (int i = 0; i < rename_pkg::slot_num; i++) begin
      excp_o[i] = '0;
      if (in_i.slot[i].valid) begin
        if (csr_has_int_i) begin
          excp_o[i] = raise(rename_pkg::ecode_int);
        end else if (in_i.slot[i].fetch_excp.valid) begin
          // fetch side already carries its own code
          excp_o[i] = in_i.slot[i].fetch_excp;
        end else if (in_i.slot[i].invalid_inst) begin
          excp_o[i] = raise(rename_pkg::ecode_ine);
        end else if (in_i.slot[i].instr_class == rename_pkg::priv &&
                     csr_plv_i == rename_pkg::plv_user) begin
          excp_o[i] = raise(rename_pkg::ecode_ipe);
        end else if (in_i.slot[i].instr_class == rename_pkg::syscall) begin
          excp_o[i] = raise(rename_pkg::ecode_sys);
        end else if (in_i.slot[i].instr_class == rename_pkg::brk) begin
          excp_o[i] = raise(rename_pkg::ecode_brk);
        end
      end
    end
  end

endmodule

/* hdl/rename_compactor.sv */
`timescale 1ns/1ps

module rename_compactor (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  rename_pkg::decode_bundle_t                   in_i,
  input  rename_pkg::excp_t [rename_pkg::slot_num-1:0] excp_i,
  input  logic                                         fl_ready_i,
  input  rename_pkg::preg_t [rename_pkg::slot_num-1:0] pdest_i,
  input  rename_pkg::preg_t [rename_pkg::slot_num-1:0] psrc0_i,
  input  rename_pkg::preg_t [rename_pkg::slot_num-1:0] psrc1_i,
  input  rename_pkg::preg_t [rename_pkg::slot_num-1:0] ppdest_i,
  output logic              [rename_pkg::slot_num-1:0] alloc_mask_o,
  output rename_pkg::slot_cnt_t                        alloc_num_o,
  output logic                                         in_ready_o,
  output logic                                         out_valid_o,
  input  logic                                         out_ready_i,
  output rename_pkg::rename_out_t                      out_o
);

  logic                    accept;
  logic                    any_valid;
  rename_pkg::rename_out_t out_d;

  // ====================
  // accept and allocation
  // ====================

  // register free now or draining on this edge
  assign in_ready_o = fl_ready_i && (!out_valid_o || out_ready_i);

  always_comb begin
    any_valid = 1'b0;
    for (int i = 0; i < rename_pkg::slot_num; i++) begin
      any_valid = any_valid | in_i.slot[i].valid;
    end
  end

  assign accept = in_ready_o && any_valid;

  always_comb begin
    alloc_num_o = '0;
    for (int i = 0; i < rename_pkg::slot_num; i++) begin
      alloc_mask_o[i] = accept && in_i.slot[i].valid && !excp_i[i].valid &&
                        (in_i.slot[i].arch_dest != '0);
      alloc_num_o     = alloc_num_o + rename_pkg::slot_cnt_t'(alloc_mask_o[i]);
    end
  end

  // ====================
  // rob and dispatch slots
  // ====================

  always_comb begin
    int disp_idx;
    disp_idx = 0;
    out_d    = '0;
    for (int i = 0; i < rename_pkg::slot_num; i++) begin
      out_d.rob[i].valid      = in_i.slot[i].valid;
      out_d.rob[i].arch_dest  = in_i.slot[i].arch_dest;
      out_d.rob[i].dest_valid = alloc_mask_o[i];
      out_d.rob[i].ppdest     = alloc_mask_o[i] ? ppdest_i[i] : '0;
      out_d.rob[i].excp       = excp_i[i];
      // exception slots stay out of dispatch
      if (in_i.slot[i].valid && !excp_i[i].valid) begin
        out_d.disp[disp_idx].valid       = 1'b1;
        out_d.disp[disp_idx].instr_class = in_i.slot[i].instr_class;
        out_d.disp[disp_idx].src0_valid  = in_i.slot[i].arch_src0 != '0;
        out_d.disp[disp_idx].src1_valid  = in_i.slot[i].arch_src1 != '0;
        out_d.disp[disp_idx].dest_valid  = alloc_mask_o[i];
        out_d.disp[disp_idx].psrc0       = psrc0_i[i];
        out_d.disp[disp_idx].psrc1       = psrc1_i[i];
        out_d.disp[disp_idx].pdest       = alloc_mask_o[i] ? pdest_i[i] : '0;
        disp_idx = disp_idx + 1;
      end
    end
  end

  // output register, held while the consumer stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
      out_o       <= '0;
    end else if (accept) begin
      out_valid_o <= 1'b1;
      out_o       <= out_d;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

endmodule

/* hdl/rename_stage.sv */
`timescale 1ns/1ps

module rename_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  rename_pkg::decode_bundle_t in_i,
  output logic                       in_ready_o,
  input  logic                       csr_has_int_i,
  input  rename_pkg::plv_t           csr_plv_i,
  input  rename_pkg::free_req_t      free_i,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output rename_pkg::rename_out_t    out_o
);

  rename_pkg::excp_t     [rename_pkg::slot_num-1:0] excp;
  logic                  [rename_pkg::slot_num-1:0] alloc_mask;
  rename_pkg::slot_cnt_t                            alloc_num;
  logic                                             fl_ready;
  rename_pkg::preg_t     [rename_pkg::slot_num-1:0] pdest;
  rename_pkg::preg_t     [rename_pkg::slot_num-1:0] psrc0;
  rename_pkg::preg_t     [rename_pkg::slot_num-1:0] psrc1;
  rename_pkg::preg_t     [rename_pkg::slot_num-1:0] ppdest;

  excp_classifier excp_classifier_inst (
    .in_i          (in_i),
    .csr_has_int_i (csr_has_int_i),
    .csr_plv_i     (csr_plv_i),
    .excp_o        (excp)
  );

  reg_renamer reg_renamer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_i         (in_i),
    .alloc_mask_i (alloc_mask),
    .alloc_num_i  (alloc_num),
    .free_i       (free_i),
    .fl_ready_o   (fl_ready),
    .pdest_o      (pdest),
    .psrc0_o      (psrc0),
    .psrc1_o      (psrc1),
    .ppdest_o     (ppdest)
  );

  rename_compactor rename_compactor_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_i         (in_i),
    .excp_i       (excp),
    .fl_ready_i   (fl_ready),
    .pdest_i      (pdest),
    .psrc0_i      (psrc0),
    .psrc1_i      (psrc1),
    .ppdest_i     (ppdest),
    .alloc_mask_o (alloc_mask),
    .alloc_num_o  (alloc_num),
    .in_ready_o   (in_ready_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_o        (out_o)
  );

endmodule

/* tb/rename_stage_properties.sv */
`timescale 1ns/1ps

module rename_stage_properties (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    in_ready_o,
  input logic                    out_valid_o,
  input logic                    out_ready_i,
  input rename_pkg::rename_out_t out_o
);

  // ====================
  // output register
  // ====================

  // empty on the first edge after reset
  reset_empty: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid_o)
    else $error("out_valid_o high right after reset");

  // stalled bundle stays put
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o))
    else $error("output changed while out_ready_i was low");

  no_accept_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |-> !in_ready_o)
    else $error("in_ready_o high while the output register is stalled");

  // dispatch slots fill from 0 upward
  disp_packed: assert property (@(posedge clk) disable iff (!rst_n)
    out_o.disp[1].valid |-> out_o.disp[0].valid)
    else $error("dispatch slot 1 valid without slot 0");

endmodule

bind rename_stage rename_stage_properties rename_stage_properties_inst (.*);

/* tb/rename_stage_tb.sv */
`timescale 1ns/1ps

module rename_stage_tb;

  localparam int n_bundles  = 2000;
  localparam int clk_period = 20;
  // generous per-bundle budget, covers stalls and an empty free list
  localparam int max_cycles = n_bundles * 20;

  logic                       clk;
  logic                       rst_n;
  rename_pkg::decode_bundle_t in_i;
  logic                       in_ready_o;
  logic                       csr_has_int_i;
  rename_pkg::plv_t           csr_plv_i;
  rename_pkg::free_req_t      free_i;
  logic                       out_valid_o;
  logic                       out_ready_i;
  rename_pkg::rename_out_t    out_o;

  integer seed;

  // reference model state
  rename_pkg::preg_t       fl_model [$];
  rename_pkg::preg_t       rat_model [rename_pkg::arch_reg_num];
  rename_pkg::preg_t       release_q [$];
  logic                    exp_valid;
  rename_pkg::rename_out_t exp_out;
  logic                    pending;
  int                      sent_cnt;
  int                      drained_cnt;

  rename_stage rename_stage_inst (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    repeat (max_cycles) @(posedge clk);
    $display("timeout: %0d of %0d bundles drained after %0d cycles",
             drained_cnt, n_bundles, max_cycles);
    $display("Test failed");
    $fatal(1);
  end

  // ====================
  // compare tasks
  // ====================

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_rob_slot(input int idx, input rename_pkg::rob_slot_t got,
                                input rename_pkg::rob_slot_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("rob slot %0d is %h, expected %h", idx, got, exp));
    end
  endtask

  task automatic check_disp_slot(input int idx, input rename_pkg::disp_slot_t got,
                                 input rename_pkg::disp_slot_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("disp slot %0d is %h, expected %h", idx, got, exp));
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
    end
  endtask

  // ====================
  // stimulus
  // ====================

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // mostly low registers so the bypass and zero-dest cases come up often
  function automatic rename_pkg::areg_t random_areg();
    if (rand_below(4) == 0) return rename_pkg::areg_t'(rand_below(32));
    return rename_pkg::areg_t'(rand_below(6));
  endfunction

  function automatic rename_pkg::decode_slot_t random_slot(input logic valid);
    rename_pkg::decode_slot_t s;
    int                       c;
    c = rand_below(100);
    s.valid = valid;
    if (c < 91) s.instr_class = rename_pkg::instr_class_e'(rand_below(4));
    else if (c < 95) s.instr_class = rename_pkg::priv;
    else if (c < 98) s.instr_class = rename_pkg::syscall;
    else s.instr_class = rename_pkg::brk;
    s.invalid_inst     = rand_below(100) < 2;
    s.fetch_excp.valid = rand_below(100) < 2;
    s.fetch_excp.ecode = rename_pkg::ecode_t'(rand_below(64));
    s.arch_src0        = random_areg();
    s.arch_src1        = random_areg();
    s.arch_dest        = random_areg();
    return s;
  endfunction

  task automatic drive_inputs();
    int v;
    if (!pending && sent_cnt < n_bundles) begin
      // at least one slot valid
      v = rand_below(3) + 1;
      in_i.slot[0] = random_slot(v[0]);
      in_i.slot[1] = random_slot(v[1]);
      pending = 1'b1;
    end else if (!pending) begin
      in_i = '0;
    end
    csr_has_int_i = rand_below(100) < 3;
    csr_plv_i     = rename_pkg::plv_t'(rand_below(4));
    out_ready_i   = rand_below(100) < 75;
    free_i        = '0;
    for (int i = 0; i < rename_pkg::slot_num; i++) begin
      if (release_q.size() > 0 && rand_below(2) == 0) begin
        free_i.valid[i] = 1'b1;
        free_i.preg[i]  = release_q.pop_front();
      end
    end
  endtask

  // ====================
  // reference model
  // ====================

  // int > fetch > ine > ipe > sys > brk
  function automatic rename_pkg::excp_t model_excp(input rename_pkg::decode_slot_t s);
    rename_pkg::excp_t e;
    e.valid = s.valid;
    e.ecode = '0;
    if (!s.valid) return e;
    if (csr_has_int_i) e.ecode = rename_pkg::ecode_int;
    else if (s.fetch_excp.valid) e.ecode = s.fetch_excp.ecode;
    else if (s.invalid_inst) e.ecode = rename_pkg::ecode_ine;
    else if (s.instr_class == rename_pkg::priv && csr_plv_i == rename_pkg::plv_user)
      e.ecode = rename_pkg::ecode_ipe;
    else if (s.instr_class == rename_pkg::syscall) e.ecode = rename_pkg::ecode_sys;
    else if (s.instr_class == rename_pkg::brk) e.ecode = rename_pkg::ecode_brk;
    else e.valid = 1'b0;
    return e;
  endfunction

  // slots renamed in order, so slot 1 sees slot 0's new mapping
  task automatic model_accept();
    rename_pkg::decode_slot_t s;
    rename_pkg::excp_t        e;
    rename_pkg::preg_t        ps0;
    rename_pkg::preg_t        ps1;
    rename_pkg::preg_t        pd;
    logic                     alloc;
    int                       d;
    exp_out = '0;
    d = 0;
    for (int i = 0; i < rename_pkg::slot_num; i++) begin
      s     = in_i.slot[i];
      e     = model_excp(s);
      alloc = s.valid && !e.valid && s.arch_dest != '0;
      ps0   = rat_model[s.arch_src0];
      ps1   = rat_model[s.arch_src1];
      pd    = '0;
      exp_out.rob[i].valid     = s.valid;
      exp_out.rob[i].arch_dest = s.arch_dest;
      exp_out.rob[i].excp      = e;
      if (alloc) begin
        pd = fl_model.pop_front();
        exp_out.rob[i].dest_valid = 1'b1;
        exp_out.rob[i].ppdest     = rat_model[s.arch_dest];
        rat_model[s.arch_dest]    = pd;
      end
      if (s.valid && !e.valid) begin
        exp_out.disp[d].valid       = 1'b1;
        exp_out.disp[d].instr_class = s.instr_class;
        exp_out.disp[d].src0_valid  = s.arch_src0 != '0;
        exp_out.disp[d].src1_valid  = s.arch_src1 != '0;
        exp_out.disp[d].dest_valid  = alloc;
        exp_out.disp[d].psrc0       = ps0;
        exp_out.disp[d].psrc1       = ps1;
        exp_out.disp[d].pdest       = pd;
        d++;
      end
    end
    exp_valid = 1'b1;
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    logic ready_exp;
    logic drain;
    seed          = 32'h27c7_3721;
    rst_n         = 1'b0;
    in_i          = '0;
    csr_has_int_i = 1'b0;
    csr_plv_i     = '0;
    free_i        = '0;
    out_ready_i   = 1'b0;
    for (int i = 0; i < rename_pkg::fl_depth; i++) begin
      fl_model.push_back(rename_pkg::preg_t'(rename_pkg::arch_reg_num + i));
    end
    for (int a = 0; a < rename_pkg::arch_reg_num; a++) begin
      rat_model[a] = rename_pkg::preg_t'(a);
    end
    exp_valid   = 1'b0;
    pending     = 1'b0;
    sent_cnt    = 0;
    drained_cnt = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    while (drained_cnt < n_bundles) begin
      @(negedge clk);
      drive_inputs();
      #1;
      ready_exp = fl_model.size() >= 2 && (!exp_valid || out_ready_i);
      check_level("in_ready_o", in_ready_o, ready_exp);
      check_level("out_valid_o", out_valid_o, exp_valid);
      // held bundle compared every cycle, so a stall must not change it
      if (exp_valid) begin
        for (int i = 0; i < rename_pkg::slot_num; i++) begin
          check_rob_slot(i, out_o.rob[i], exp_out.rob[i]);
          check_disp_slot(i, out_o.disp[i], exp_out.disp[i]);
        end
      end
      drain = exp_valid && out_ready_i;
      if (drain) begin
        for (int i = 0; i < rename_pkg::slot_num; i++) begin
          if (exp_out.rob[i].dest_valid) release_q.push_back(exp_out.rob[i].ppdest);
        end
        drained_cnt++;
      end
      // what the coming edge does to the model
      if (ready_exp && pending) begin
        model_accept();
        pending = 1'b0;
        sent_cnt++;
      end else if (drain) begin
        exp_valid = 1'b0;
      end
      for (int i = 0; i < rename_pkg::slot_num; i++) begin
        if (free_i.valid[i]) fl_model.push_back(free_i.preg[i]);
      end
    end

    // last bundle drained on the edge just passed
    @(negedge clk);
    #1;
    if (out_valid_o === 1'b0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Fail at %0t: out_valid_o is %b after the last bundle drained",
               $time, out_valid_o);
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule

/* vlog.f */
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/alias_table.sv
hdl/reg_renamer.sv
hdl/excp_classifier.sv
hdl/rename_compactor.sv
hdl/rename_stage.sv
tb/rename_stage_properties.sv
tb/rename_stage_tb.sv

/* Makefile */
TOP := rename_stage_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
